//--- project.f
src/cpu_cfg_pkg.sv
src/wb_types_pkg.sv
src/wbu.sv
src/regfile.sv
src/perf_counter.sv
src/csr_file.sv
src/intr_ctrl.sv
src/wb_subsys.sv
sim/wb_subsys_sva.sv
sim/tb_wb_subsys.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_wb_subsys
LINT_TOP  ?= wb_subsys
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_wb_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsys;

  localparam int NUM_ENTRIES = 16;
  localparam int WAIT_LIMIT  = 200;

  logic                                 i_clk = 1'b0;
  logic                                 i_rst_n;
  logic                                 i_lsu_valid;
  wb_types_pkg::lsu_wb_t                i_lsu_data;
  logic                                 i_wb_ready = 1'b0;
  logic                                 i_irq;
  logic [cpu_cfg_pkg::REG_ADDRW-1:0]    i_rs_addr = '0;
  logic [cpu_cfg_pkg::CSR_ADDRW-1:0]    i_csr_raddr;
  logic                                 o_lsu_ready;
  logic                                 o_commit;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_commit_pc;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_rs_data;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_csr_rdata;
  logic                                 o_redirect;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_redirect_pc;

  // stimulus table with one lsu result and one irq flag per row
  wb_types_pkg::lsu_wb_t  tbl_data [NUM_ENTRIES];
  logic                   tbl_irq  [NUM_ENTRIES];
  int                     n_entries;
  wb_types_pkg::lsu_wb_t  exp_q [$];
  wb_types_pkg::lsu_wb_t  mon_entry;

  // software model of the architectural state
  logic [31:0]  model_regs [32];
  logic         m_mie;
  logic         m_mpie;
  logic [31:0]  m_mtvec;
  logic [31:0]  m_mscratch;
  logic [31:0]  m_mepc;
  logic [31:0]  m_mcause;
  logic [31:0]  irq_pc;
  logic [31:0]  irq_mtvec;

  int           errors;
  int           commit_cnt;
  int           redirect_cnt;
  int           seed = 5;
  int           rnd;
  logic         timed_out;
  logic         bp_en = 1'b0;
  logic         chk_valid = 1'b0;
  logic [4:0]   chk_addr;
  logic [31:0]  chk_data;
  logic [4:0]   final_rs_addr = '0;

  wb_subsys i_wb_subsys (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_lsu_valid   (i_lsu_valid),
    .o_lsu_ready   (o_lsu_ready),
    .i_lsu_data    (i_lsu_data),
    .i_wb_ready    (i_wb_ready),
    .i_irq         (i_irq),
    .i_rs_addr     (i_rs_addr),
    .i_csr_raddr   (i_csr_raddr),
    .o_commit      (o_commit),
    .o_commit_pc   (o_commit_pc),
    .o_rs_data     (o_rs_data),
    .o_csr_rdata   (o_csr_rdata),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

  always #2 i_clk = ~i_clk;

  // random writeback stall while the table runs
  always @(posedge i_clk) begin
    rnd = $random(seed);
    if (bp_en) begin
      i_wb_ready <= rnd[0];
    end else begin
      i_wb_ready <= 1'b1;
    end
  end

  // read port follows the last commit or else the final sweep
  always @(posedge i_clk) begin
    if (chk_valid) begin
      i_rs_addr <= chk_addr;
    end else begin
      i_rs_addr <= final_rs_addr;
    end
  end

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic add_entry(input logic [31:0] exres, input logic [31:0] lsres, input logic lden,
                           input logic [4:0] rdid, input logic rdwen, input logic [11:0] csrdid,
                           input logic csrdwen, input logic [31:0] csrd, input logic irq);
    wb_types_pkg::lsu_wb_t e;
    e.exres   = exres;
    e.lsres   = lsres;
    e.lden    = lden;
    e.rdid    = rdid;
    e.rdwen   = rdwen;
    e.csrdid  = csrdid;
    e.csrdwen = csrdwen;
    e.csrd    = csrd;
    e.pc      = 32'h0000_1000 + 32'(n_entries * 4);
    e.ins     = {e.pc[29:0], 2'b11};
    e.nop     = 1'b0;
    tbl_data[n_entries] = e;
    tbl_irq[n_entries]  = irq;
    n_entries++;
  endtask

  task automatic build_table();
    n_entries = 0;
    add_entry(32'h1111_1111, 32'h0, 1'b0, 5'd1, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0000_DEAD, 32'hCAFE_0002, 1'b1, 5'd2, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    // x0 write and a write with rdwen clear
    add_entry(32'h1234_5678, 32'h0, 1'b0, 5'd0, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0000_FFFF, 32'h0, 1'b0, 5'd1, 1'b0, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0000_0033, 32'h0, 1'b0, 5'd3, 1'b1, cpu_cfg_pkg::CSR_MSCRATCH, 1'b1,
              32'hA5A5_5A5A, 1'b0);
    add_entry(32'h0, 32'h0, 1'b0, 5'd0, 1'b0, cpu_cfg_pkg::CSR_MTVEC, 1'b1, 32'h0000_8000, 1'b0);
    add_entry(32'h0, 32'h0, 1'b0, 5'd0, 1'b0, cpu_cfg_pkg::CSR_MCYCLEH, 1'b1,
              32'h0000_FFFF, 1'b0);
    add_entry(32'h0, 32'h0, 1'b0, 5'd0, 1'b0, cpu_cfg_pkg::CSR_MINSTRET, 1'b1,
              32'h0000_0055, 1'b0);
    add_entry(32'h0, 32'h0, 1'b0, 5'd0, 1'b0, cpu_cfg_pkg::CSR_MSTATUS, 1'b1,
              32'h0000_0008, 1'b0);
    add_entry(32'h0, 32'h0000_0044, 1'b1, 5'd4, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    // this one is replaced by the interrupt
    add_entry(32'h5555_5555, 32'h0, 1'b0, 5'd5, 1'b1, cpu_cfg_pkg::CSR_MSCRATCH, 1'b1,
              32'hBAD0_BAD0, 1'b1);
    add_entry(32'h0000_0066, 32'h0, 1'b0, 5'd5, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0, 32'h0000_0077, 1'b1, 5'd6, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0000_0099, 32'h0, 1'b0, 5'd1, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0000_0ABC, 32'hFFFF_0000, 1'b0, 5'd7, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
    add_entry(32'h0000_0001, 32'h8888_0008, 1'b1, 5'd8, 1'b1, 12'h0, 1'b0, 32'h0, 1'b0);
  endtask

  // walk the table in order and predict commits and CSR state
  task automatic build_expected();
    wb_types_pkg::lsu_wb_t e;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    {m_mie, m_mpie, m_mtvec, m_mscratch, m_mepc, m_mcause} = '0;
    irq_pc    = 32'hFFFF_FFFF;
    irq_mtvec = '0;
    for (int i = 0; i < n_entries; i++) begin
      e = tbl_data[i];
      if (tbl_irq[i] && m_mie && !e.nop) begin
        irq_pc    = e.pc;
        irq_mtvec = m_mtvec;
        m_mepc    = e.pc;
        m_mcause  = cpu_cfg_pkg::CAUSE_MEXT;
        m_mpie    = m_mie;
        m_mie     = 1'b0;
      end else begin
        exp_q.push_back(e);
        if (e.csrdwen) begin
          case (e.csrdid)
            cpu_cfg_pkg::CSR_MSTATUS: begin
              m_mie  = e.csrd[cpu_cfg_pkg::MIE_BIT];
              m_mpie = e.csrd[cpu_cfg_pkg::MPIE_BIT];
            end
            cpu_cfg_pkg::CSR_MTVEC:    m_mtvec    = e.csrd;
            cpu_cfg_pkg::CSR_MSCRATCH: m_mscratch = e.csrd;
            cpu_cfg_pkg::CSR_MEPC:     m_mepc     = e.csrd;
            cpu_cfg_pkg::CSR_MCAUSE:   m_mcause   = e.csrd;
            default: ;
          endcase
        end
      end
    end
  endtask

  // commit monitor that reads the register back one cycle after its commit
  always @(negedge i_clk) begin
    if (chk_valid) begin
      check_hex($sformatf("o_rs_data[x%0d]", chk_addr), o_rs_data, chk_data);
    end
    chk_valid = 1'b0;
    if (o_commit === 1'b1) begin
      commit_cnt++;
      if (o_commit_pc == irq_pc) begin
        $display("interrupted instruction at pc 0x%08h was committed", o_commit_pc);
        errors++;
      end
      if (exp_q.size() == 0) begin
        $display("commit with pc 0x%08h when no commit was expected", o_commit_pc);
        errors++;
      end else begin
        mon_entry = exp_q.pop_front();
        check_hex("o_commit_pc", o_commit_pc, mon_entry.pc);
        if (mon_entry.rdwen && mon_entry.rdid != 5'd0) begin
          model_regs[mon_entry.rdid] = mon_entry.lden ? mon_entry.lsres : mon_entry.exres;
        end
        chk_valid = 1'b1;
        chk_addr  = mon_entry.rdid;
        chk_data  = model_regs[mon_entry.rdid];
      end
    end
    if (o_redirect === 1'b1) begin
      redirect_cnt++;
      check_hex("o_redirect_pc", o_redirect_pc, irq_mtvec);
    end
  end

  // called at a rising edge and returns at the edge that accepts the entry
  task automatic send_entry(input int idx);
    int cnt;
    cnt = 0;
    i_lsu_valid <= 1'b1;
    i_lsu_data  <= tbl_data[idx];
    @(negedge i_clk);
    while (!o_lsu_ready && cnt < WAIT_LIMIT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (!o_lsu_ready) begin
      $display("entry %0d was never accepted by the wbu", idx);
      errors++;
      timed_out = 1'b1;
    end else begin
      @(posedge i_clk);
    end
  endtask

  task automatic wait_redirect();
    int cnt;
    cnt = 0;
    @(negedge i_clk);
    while (!o_redirect && cnt < WAIT_LIMIT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (!o_redirect) begin
      $display("interrupt was never taken, no redirect seen");
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < WAIT_LIMIT) begin
      @(negedge i_clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected commits never happened", exp_q.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    @(posedge i_clk);
    i_csr_raddr <= addr;
    @(negedge i_clk);
    data = o_csr_rdata;
  endtask

  task automatic read_reg(input logic [4:0] addr, output logic [31:0] data);
    final_rs_addr = addr;
    @(posedge i_clk);
    @(negedge i_clk);
    data = o_rs_data;
  endtask

  task automatic final_checks();
    logic [31:0] d;
    logic [31:0] c1;
    logic [31:0] c2;
    for (int r = 0; r < 32; r++) begin
      read_reg(5'(r), d);
      check_hex($sformatf("x%0d", r), d, model_regs[r]);
    end
    read_csr(cpu_cfg_pkg::CSR_MSCRATCH, d);
    check_hex("mscratch", d, m_mscratch);
    read_csr(cpu_cfg_pkg::CSR_MTVEC, d);
    check_hex("mtvec", d, m_mtvec);
    read_csr(cpu_cfg_pkg::CSR_MEPC, d);
    check_hex("mepc", d, m_mepc);
    read_csr(cpu_cfg_pkg::CSR_MCAUSE, d);
    check_hex("mcause", d, m_mcause);
    // after the trap MIE is clear and MPIE holds the old MIE
    read_csr(cpu_cfg_pkg::CSR_MSTATUS, d);
    check_hex("mstatus", d, (32'(m_mpie) << cpu_cfg_pkg::MPIE_BIT) |
                            (32'(m_mie) << cpu_cfg_pkg::MIE_BIT));
    read_csr(cpu_cfg_pkg::CSR_MINSTRET, d);
    check_hex("minstret", d, 32'(commit_cnt));
    read_csr(cpu_cfg_pkg::CSR_MINSTRETH, d);
    check_hex("minstreth", d, 32'h0);
    read_csr(cpu_cfg_pkg::CSR_MCYCLEH, d);
    check_hex("mcycleh", d, 32'h0);
    read_csr(cpu_cfg_pkg::CSR_MCYCLE, c1);
    read_csr(cpu_cfg_pkg::CSR_MCYCLE, c2);
    if (c2 <= c1) begin
      $display("mcycle did not increase between two reads (0x%08h then 0x%08h)", c1, c2);
      errors++;
    end
    if (redirect_cnt != 1) begin
      $display("expected exactly one redirect, saw %0d", redirect_cnt);
      errors++;
    end
    if (i_wb_subsys.u_wbu.u_wb_subsys_sva.fail_cnt != 0) begin
      $display("bound assertions failed %0d times", i_wb_subsys.u_wbu.u_wb_subsys_sva.fail_cnt);
      errors++;
    end
  endtask

  initial begin
    errors       = 0;
    commit_cnt   = 0;
    redirect_cnt = 0;
    timed_out    = 1'b0;
    i_rst_n      = 1'b0;
    i_lsu_valid  = 1'b0;
    i_lsu_data   = '0;
    i_irq        = 1'b0;
    i_csr_raddr  = '0;
    build_table();
    build_expected();
    repeat (3) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(negedge i_clk);
    if (o_commit !== 1'b0 || o_redirect !== 1'b0 || o_lsu_ready !== 1'b1) begin
      $display("outputs not in their idle state after reset");
      errors++;
    end
    bp_en = 1'b1;
    @(posedge i_clk);
    begin : run_seq
      for (int i = 0; i < n_entries; i++) begin
        send_entry(i);
        if (timed_out) disable run_seq;
        if (tbl_irq[i]) begin
          // only the irq entry sits in the wbu from this edge on
          i_lsu_valid <= 1'b0;
          i_irq       <= 1'b1;
          wait_redirect();
          if (timed_out) disable run_seq;
          @(posedge i_clk);
          i_irq <= 1'b0;
        end
      end
      i_lsu_valid <= 1'b0;
      @(negedge i_clk);
      bp_en = 1'b0;
      wait_drain();
      if (timed_out) disable run_seq;
      repeat (2) @(negedge i_clk);
      final_checks();
    end
    $display("errors: %0d, commits: %0d, redirects: %0d", errors, commit_cnt, redirect_cnt);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/wb_subsys_sva.sv
`timescale 1ns/1ps
`default_nettype none

module wb_subsys_sva (
  input   logic                   i_clk,
  input   logic                   i_rst_n,
  input   logic                   i_flush,
  input   logic                   i_intr,
  input   logic                   i_pre_valid,
  input   logic                   o_pre_ready,
  input   wb_types_pkg::lsu_wb_t  i_pre_data,
  input   logic                   o_post_valid,
  input   logic                   o_commit
);

  int unsigned fail_cnt = 0;

  // a stalled producer keeps valid and payload unchanged
  property p_pre_hold;
    @(posedge i_clk) disable iff (!i_rst_n)
      (i_pre_valid && !o_pre_ready) |=> (i_pre_valid && $stable(i_pre_data));
  endproperty

  // the interrupted slot retires nothing and the trap cycle flushes the wbu
  property p_no_commit_on_intr;
    @(posedge i_clk) disable iff (!i_rst_n)
      i_intr |-> !o_commit ##1 i_flush;
  endproperty

  property p_flush_empties;
    @(posedge i_clk) disable iff (!i_rst_n)
      i_flush |=> !o_post_valid;
  endproperty

  a_pre_hold: assert property (p_pre_hold)
    else begin
      $error("lsu payload changed while waiting for ready");
      fail_cnt++;
    end

  a_no_commit_on_intr: assert property (p_no_commit_on_intr)
    else begin
      $error("interrupt take committed or was not followed by a flush");
      fail_cnt++;
    end

  a_flush_empties: assert property (p_flush_empties)
    else begin
      $error("wbu still valid one cycle after flush");
      fail_cnt++;
    end

endmodule

bind wbu wb_subsys_sva u_wb_subsys_sva (.*);

`default_nettype wire

//--- src/wb_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module wb_subsys (
  input   logic                                 i_clk,
  input   logic                                 i_rst_n,
  input   logic                                 i_lsu_valid,
  output  logic                                 o_lsu_ready,
  input   wb_types_pkg::lsu_wb_t                i_lsu_data,
  input   logic                                 i_wb_ready,
  input   logic                                 i_irq,
  input   logic [cpu_cfg_pkg::REG_ADDRW-1:0]    i_rs_addr,
  input   logic [cpu_cfg_pkg::CSR_ADDRW-1:0]    i_csr_raddr,
  output  logic                                 o_commit,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_commit_pc,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_rs_data,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_csr_rdata,
  output  logic                                 o_redirect,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_redirect_pc
);

  wb_types_pkg::reg_wr_t              reg_wr;
  wb_types_pkg::csr_wr_t              csr_wr;
  wb_types_pkg::trap_t                trap;
  logic                               flush;
  logic                               intr;
  logic                               wb_fire;
  logic                               wb_nop;
  logic                               mie;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  mtvec;
  logic [cpu_cfg_pkg::CNT_WIDTH-1:0]  mcycle;
  logic [cpu_cfg_pkg::CNT_WIDTH-1:0]  minstret;

  wbu u_wbu (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_flush      (flush),
    .i_intr       (intr),
    .i_pre_valid  (i_lsu_valid),
    .o_pre_ready  (o_lsu_ready),
    .i_pre_data   (i_lsu_data),
    .o_post_valid (),
    .i_post_ready (i_wb_ready),
    .o_wb_fire    (wb_fire),
    .o_commit     (o_commit),
    .o_reg_wr     (reg_wr),
    .o_csr_wr     (csr_wr),
    .o_wb_pc      (o_commit_pc),
    .o_wb_ins     (),
    .o_wb_nop     (wb_nop)
  );

  regfile u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wr      (reg_wr),
    .i_rs_addr (i_rs_addr),
    .o_rs_data (o_rs_data)
  );

  perf_counter u_perf_counter (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_commit   (o_commit),
    .o_mcycle   (mcycle),
    .o_minstret (minstret)
  );

  csr_file u_csr_file (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wr       (csr_wr),
    .i_trap     (trap),
    .i_mcycle   (mcycle),
    .i_minstret (minstret),
    .i_raddr    (i_csr_raddr),
    .o_rdata    (o_csr_rdata),
    .o_mie      (mie),
    .o_mtvec    (mtvec)
  );

  intr_ctrl u_intr_ctrl (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_irq         (i_irq),
    .i_mie         (mie),
    .i_mtvec       (mtvec),
    .i_wb_fire     (wb_fire),
    .i_wb_nop      (wb_nop),
    .i_wb_pc       (o_commit_pc),
    .o_intr        (intr),
    .o_flush       (flush),
    .o_trap        (trap),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

endmodule

`default_nettype wire

//--- src/intr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module intr_ctrl (
  input   logic                                 i_clk,
  input   logic                                 i_rst_n,
  input   logic                                 i_irq,
  input   logic                                 i_mie,
  input   logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    i_mtvec,
  input   logic                                 i_wb_fire,
  input   logic                                 i_wb_nop,
  input   logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    i_wb_pc,
  output  logic                                 o_intr,
  output  logic                                 o_flush,
  output  wb_types_pkg::trap_t                  o_trap,
  output  logic                                 o_redirect,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_redirect_pc
);

  wb_types_pkg::intr_state_e          state_q;
  wb_types_pkg::intr_state_e          state_d;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  epc_q;
  logic                               take;
  logic                               in_trap;

  // take on a real instruction leaving writeback, never on a bubble
  assign take    = (state_q == wb_types_pkg::ST_IDLE) & i_irq & i_mie & i_wb_fire & ~i_wb_nop;
  assign in_trap = (state_q == wb_types_pkg::ST_TRAP);

  always_comb begin
    state_d = state_q;
    case (state_q)
      wb_types_pkg::ST_IDLE: if (take) state_d = wb_types_pkg::ST_TRAP;
      wb_types_pkg::ST_TRAP: state_d = wb_types_pkg::ST_IDLE;
      default:               state_d = wb_types_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= wb_types_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // pc of the instruction that gave up its slot
  always_ff @(posedge i_clk) begin
    if (take) begin
      epc_q <= i_wb_pc;
    end
  end

  assign o_intr        = take;
  assign o_flush       = in_trap;
  assign o_trap.valid  = in_trap;
  assign o_trap.epc    = epc_q;
  assign o_trap.cause  = cpu_cfg_pkg::CAUSE_MEXT;
  assign o_redirect    = in_trap;
  assign o_redirect_pc = i_mtvec;

endmodule

`default_nettype wire

//--- src/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
  input   logic                                 i_clk,
  input   logic                                 i_rst_n,
  input   wb_types_pkg::csr_wr_t                i_wr,
  input   wb_types_pkg::trap_t                  i_trap,
  input   logic [cpu_cfg_pkg::CNT_WIDTH-1:0]    i_mcycle,
  input   logic [cpu_cfg_pkg::CNT_WIDTH-1:0]    i_minstret,
  input   logic [cpu_cfg_pkg::CSR_ADDRW-1:0]    i_raddr,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_rdata,
  output  logic                                 o_mie,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_mtvec
);

  logic                               mie_q;
  logic                               mpie_q;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  mtvec_q;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  mscratch_q;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  mepc_q;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  mcause_q;
  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]  mstatus;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mie_q      <= 1'b0;
      mpie_q     <= 1'b0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (i_trap.valid) begin
      // trap entry wins over any instruction write
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
      mepc_q   <= i_trap.epc;
      mcause_q <= i_trap.cause;
    end else if (i_wr.wen) begin
      case (i_wr.addr)
        cpu_cfg_pkg::CSR_MSTATUS: begin
          mie_q  <= i_wr.data[cpu_cfg_pkg::MIE_BIT];
          mpie_q <= i_wr.data[cpu_cfg_pkg::MPIE_BIT];
        end
        cpu_cfg_pkg::CSR_MTVEC:    mtvec_q    <= i_wr.data;
        cpu_cfg_pkg::CSR_MSCRATCH: mscratch_q <= i_wr.data;
        cpu_cfg_pkg::CSR_MEPC:     mepc_q     <= i_wr.data;
        cpu_cfg_pkg::CSR_MCAUSE:   mcause_q   <= i_wr.data;
        // counters are read-only here
        default: ;
      endcase
    end
  end

  // only MIE and MPIE exist in mstatus
  always_comb begin
    mstatus                        = '0;
    mstatus[cpu_cfg_pkg::MIE_BIT]  = mie_q;
    mstatus[cpu_cfg_pkg::MPIE_BIT] = mpie_q;
  end

  always_comb begin
    case (i_raddr)
      cpu_cfg_pkg::CSR_MSTATUS:   o_rdata = mstatus;
      cpu_cfg_pkg::CSR_MTVEC:     o_rdata = mtvec_q;
      cpu_cfg_pkg::CSR_MSCRATCH:  o_rdata = mscratch_q;
      cpu_cfg_pkg::CSR_MEPC:      o_rdata = mepc_q;
      cpu_cfg_pkg::CSR_MCAUSE:    o_rdata = mcause_q;
      cpu_cfg_pkg::CSR_MCYCLE:    o_rdata = i_mcycle[31:0];
      cpu_cfg_pkg::CSR_MCYCLEH:   o_rdata = i_mcycle[63:32];
      cpu_cfg_pkg::CSR_MINSTRET:  o_rdata = i_minstret[31:0];
      cpu_cfg_pkg::CSR_MINSTRETH: o_rdata = i_minstret[63:32];
      default:                    o_rdata = '0;
    endcase
  end

  assign o_mie   = mie_q;
  assign o_mtvec = mtvec_q;

endmodule

`default_nettype wire

//--- src/perf_counter.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counter (
  input   logic                                 i_clk,
  input   logic                                 i_rst_n,
  input   logic                                 i_commit,
  output  logic [cpu_cfg_pkg::CNT_WIDTH-1:0]    o_mcycle,
  output  logic [cpu_cfg_pkg::CNT_WIDTH-1:0]    o_minstret
);

  // free-running cycle count
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_mcycle <= '0;
    end else begin
      o_mcycle <= o_mcycle + 1'b1;
    end
  end

  // one count per retired instruction
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_minstret <= '0;
    end else if (i_commit) begin
      o_minstret <= o_minstret + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input   logic                                 i_clk,
  input   logic                                 i_rst_n,
  input   wb_types_pkg::reg_wr_t                i_wr,
  input   logic [cpu_cfg_pkg::REG_ADDRW-1:0]    i_rs_addr,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_rs_data
);

  localparam int NUM_REGS = 2 ** cpu_cfg_pkg::REG_ADDRW;

  logic [cpu_cfg_pkg::CPU_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.wen && (i_wr.addr != '0)) begin
      // x0 is hardwired, writes to it are dropped
      regs[i_wr.addr] <= i_wr.data;
    end
  end

  // combinational read, x0 forced to zero
  assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];

endmodule

`default_nettype wire

//--- src/wbu.sv
`timescale 1ns/1ps
`default_nettype none

module wbu (
  input   logic                                 i_clk,
  input   logic                                 i_rst_n,
  input   logic                                 i_flush,
  input   logic                                 i_intr,
  input   logic                                 i_pre_valid,
  output  logic                                 o_pre_ready,
  input   wb_types_pkg::lsu_wb_t                i_pre_data,
  output  logic                                 o_post_valid,
  input   logic                                 i_post_ready,
  output  logic                                 o_wb_fire,
  output  logic                                 o_commit,
  output  wb_types_pkg::reg_wr_t                o_reg_wr,
  output  wb_types_pkg::csr_wr_t                o_csr_wr,
  output  logic [cpu_cfg_pkg::CPU_WIDTH-1:0]    o_wb_pc,
  output  logic [cpu_cfg_pkg::INS_WIDTH-1:0]    o_wb_ins,
  output  logic                                 o_wb_nop
);

  logic                   valid_q;
  logic                   pre_fire;
  wb_types_pkg::lsu_wb_t  data_q;

  // accept when empty or when the held entry leaves this cycle
  assign o_pre_ready  = ~valid_q | i_post_ready;
  assign pre_fire     = i_pre_valid & o_pre_ready;
  assign o_post_valid = valid_q;
  assign o_wb_fire    = valid_q & i_post_ready;
  // an interrupt takes the slot of the retiring instruction
  assign o_commit     = o_wb_fire & ~i_intr;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (i_flush) begin
      valid_q <= 1'b0;
    end else if (o_pre_ready) begin
      valid_q <= i_pre_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_flush) begin
      data_q <= '0;
    end else if (pre_fire) begin
      data_q <= i_pre_data;
    end
  end

  always_comb begin
    o_reg_wr.wen  = o_commit & data_q.rdwen;
    o_reg_wr.addr = data_q.rdid;
    // loads write back the memory result
    o_reg_wr.data = data_q.lden ? data_q.lsres : data_q.exres;
    o_csr_wr.wen  = o_commit & data_q.csrdwen;
    o_csr_wr.addr = data_q.csrdid;
    o_csr_wr.data = data_q.csrd;
  end

  assign o_wb_pc  = data_q.pc;
  assign o_wb_ins = data_q.ins;
  assign o_wb_nop = data_q.nop;

endmodule

`default_nettype wire

//--- src/wb_types_pkg.sv
`default_nettype none

package wb_types_pkg;

  // result handed over by the load/store stage
  typedef struct packed {
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] exres;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] lsres;
    logic                              lden;
    logic [cpu_cfg_pkg::REG_ADDRW-1:0] rdid;
    logic                              rdwen;
    logic [cpu_cfg_pkg::CSR_ADDRW-1:0] csrdid;
    logic                              csrdwen;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] csrd;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] pc;
    logic [cpu_cfg_pkg::INS_WIDTH-1:0] ins;
    logic                              nop;
  } lsu_wb_t;

  // integer register file write
  typedef struct packed {
    logic                              wen;
    logic [cpu_cfg_pkg::REG_ADDRW-1:0] addr;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] data;
  } reg_wr_t;

  // CSR write from a retiring instruction
  typedef struct packed {
    logic                              wen;
    logic [cpu_cfg_pkg::CSR_ADDRW-1:0] addr;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] data;
  } csr_wr_t;

  // trap entry, updates mepc, mcause and mstatus together
  typedef struct packed {
    logic                              valid;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] epc;
    logic [cpu_cfg_pkg::CPU_WIDTH-1:0] cause;
  } trap_t;

  typedef enum logic [0:0] {
    ST_IDLE = 1'b0,
    ST_TRAP = 1'b1
  } intr_state_e;

endpackage

`default_nettype wire

//--- src/cpu_cfg_pkg.sv
`default_nettype none

package cpu_cfg_pkg;

  // datapath widths
  localparam int CPU_WIDTH = 32;
  localparam int INS_WIDTH = 32;
  localparam int REG_ADDRW = 5;
  localparam int CSR_ADDRW = 12;
  localparam int CNT_WIDTH = 64;

  // machine CSR addresses
  localparam logic [CSR_ADDRW-1:0] CSR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDRW-1:0] CSR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDRW-1:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [CSR_ADDRW-1:0] CSR_MEPC      = 12'h341;
  localparam logic [CSR_ADDRW-1:0] CSR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDRW-1:0] CSR_MCYCLE    = 12'hB00;
  localparam logic [CSR_ADDRW-1:0] CSR_MINSTRET  = 12'hB02;
  localparam logic [CSR_ADDRW-1:0] CSR_MCYCLEH   = 12'hB80;
  localparam logic [CSR_ADDRW-1:0] CSR_MINSTRETH = 12'hB82;

  // mstatus bit positions
  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;

  // machine external interrupt, msb marks an interrupt cause
  localparam logic [CPU_WIDTH-1:0] CAUSE_MEXT = 32'h8000_000B;

endpackage

`default_nettype wire
